//--- hdl/mc_pkg.sv
// shared widths, opcode type, load info struct and payload union

package mc_pkg;

  // word and field widths
  localparam int data_width_c   = 32;
  localparam int mask_width_c   = data_width_c / 8;
  localparam int reg_id_width_c = 5;

  // link opcode
  typedef enum logic {
    mc_op_load_e  = 1'b0,
    mc_op_store_e = 1'b1
  } mc_op_e;

  // payload view for a load
  typedef struct packed {
    logic [23:0]               pad;
    logic                      is_byte;
    logic [1:0]                byte_sel;
    logic [reg_id_width_c-1:0] reg_id;
  } mc_load_info_s;

  // one payload word, decoded by opcode
  typedef union packed {
    logic [data_width_c-1:0] store_data;
    mc_load_info_s           load_info;
  } mc_payload_u;

endpackage

//--- hdl/mc_req_issuer.sv
// mc_req_issuer: registers host load/store commands into link packets

`timescale 1ns/1ps

module mc_req_issuer #(
  parameter int addr_width_p = 10
) (
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              cmd_v_i,
  input  mc_pkg::mc_op_e                    cmd_op_i,
  input  logic [addr_width_p-1:0]           cmd_addr_i,
  input  logic [mc_pkg::mask_width_c-1:0]   cmd_mask_i,
  input  mc_pkg::mc_payload_u               cmd_payload_i,
  output logic                              cmd_ready_o,

  output logic                              pkt_v_o,
  output mc_pkg::mc_op_e                    pkt_op_o,
  output logic [addr_width_p-1:0]           pkt_addr_o,
  output logic [mc_pkg::mask_width_c-1:0]   pkt_mask_o,
  output mc_pkg::mc_payload_u               pkt_payload_o,
  input  logic                              pkt_ready_i,

  output logic                              cmd_fire_o,
  output logic                              stall_o
);

  import mc_pkg::*;

  logic                    live_r;
  logic                    pkt_v_r;
  mc_op_e                  pkt_op_r;
  logic [addr_width_p-1:0] pkt_addr_r;
  logic [mask_width_c-1:0] pkt_mask_r;
  mc_payload_u             pkt_payload_r;
  logic                    cmd_fire;

  // open while the register is empty or draining this cycle
  assign cmd_ready_o = live_r & (~pkt_v_r | pkt_ready_i);
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  // profiler taps
  assign cmd_fire_o = cmd_fire;
  assign stall_o    = cmd_v_i & ~cmd_ready_o;

  always_ff @(posedge clk) begin
    if (!reset) begin
      live_r  <= 1'b0;
      pkt_v_r <= 1'b0;
    end else begin
      live_r <= 1'b1;
      if (cmd_fire) begin
        pkt_v_r <= 1'b1;
      end else if (pkt_ready_i) begin
        pkt_v_r <= 1'b0;
      end
    end
  end

  // packet fields
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      pkt_op_r      <= cmd_op_i;
      pkt_addr_r    <= cmd_addr_i;
      pkt_payload_r <= cmd_payload_i;
      // loads carry their width in load_info
      if (cmd_op_i == mc_op_load_e) begin
        pkt_mask_r <= '1;
      end else begin
        pkt_mask_r <= cmd_mask_i;
      end
    end
  end

  assign pkt_v_o       = pkt_v_r;
  assign pkt_op_o      = pkt_op_r;
  assign pkt_addr_o    = pkt_addr_r;
  assign pkt_mask_o    = pkt_mask_r;
  assign pkt_payload_o = pkt_payload_r;

endmodule

//--- hdl/mc_pkt_fifo.sv
// mc_pkt_fifo: circular packet buffer with valid/ready on both sides

`timescale 1ns/1ps

module mc_pkt_fifo #(
  parameter int addr_width_p = 10,
  parameter int fifo_els_p   = 4
) (
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              v_i,
  input  mc_pkg::mc_op_e                    op_i,
  input  logic [addr_width_p-1:0]           addr_i,
  input  logic [mc_pkg::mask_width_c-1:0]   mask_i,
  input  mc_pkg::mc_payload_u               payload_i,
  output logic                              ready_o,

  output logic                              v_o,
  output mc_pkg::mc_op_e                    op_o,
  output logic [addr_width_p-1:0]           addr_o,
  output logic [mc_pkg::mask_width_c-1:0]   mask_o,
  output mc_pkg::mc_payload_u               payload_o,
  input  logic                              ready_i
);

  import mc_pkg::*;

  localparam int lg_els_lp = $clog2(fifo_els_p);

  mc_op_e                  op_mem      [fifo_els_p];
  logic [addr_width_p-1:0] addr_mem    [fifo_els_p];
  logic [mask_width_c-1:0] mask_mem    [fifo_els_p];
  mc_payload_u             payload_mem [fifo_els_p];

  // msb is the wrap bit
  logic [lg_els_lp:0] wptr_r;
  logic [lg_els_lp:0] rptr_r;
  // write pointer as seen by the read side, one cycle behind
  logic [lg_els_lp:0] wptr_vis_r;

  logic full;
  logic empty;
  logic enq;
  logic deq;

  assign full  = (wptr_r[lg_els_lp] != rptr_r[lg_els_lp])
              && (wptr_r[lg_els_lp-1:0] == rptr_r[lg_els_lp-1:0]);
  assign empty = (wptr_vis_r == rptr_r);

  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign enq     = v_i & ~full;
  assign deq     = ~empty & ready_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      wptr_r     <= '0;
      wptr_vis_r <= '0;
      rptr_r     <= '0;
    end else begin
      wptr_vis_r <= wptr_r;
      if (enq) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= rptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enq) begin
      op_mem[wptr_r[lg_els_lp-1:0]]      <= op_i;
      addr_mem[wptr_r[lg_els_lp-1:0]]    <= addr_i;
      mask_mem[wptr_r[lg_els_lp-1:0]]    <= mask_i;
      payload_mem[wptr_r[lg_els_lp-1:0]] <= payload_i;
    end
  end

  assign op_o      = op_mem[rptr_r[lg_els_lp-1:0]];
  assign addr_o    = addr_mem[rptr_r[lg_els_lp-1:0]];
  assign mask_o    = mask_mem[rptr_r[lg_els_lp-1:0]];
  assign payload_o = payload_mem[rptr_r[lg_els_lp-1:0]];

endmodule

//--- hdl/mc_mem_endpoint.sv
// mc_mem_endpoint: runs link packets against a word memory, one response each

`timescale 1ns/1ps

module mc_mem_endpoint #(
  parameter int addr_width_p = 10
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                pkt_v_i,
  input  mc_pkg::mc_op_e                      pkt_op_i,
  input  logic [addr_width_p-1:0]             pkt_addr_i,
  input  logic [mc_pkg::mask_width_c-1:0]     pkt_mask_i,
  input  mc_pkg::mc_payload_u                 pkt_payload_i,
  output logic                                pkt_ready_o,

  output logic                                resp_v_o,
  output mc_pkg::mc_op_e                      resp_op_o,
  output logic [mc_pkg::reg_id_width_c-1:0]   resp_reg_id_o,
  output logic [mc_pkg::data_width_c-1:0]     resp_data_o,
  input  logic                                resp_ready_i
);

  import mc_pkg::*;

  logic [data_width_c-1:0]   mem [2**addr_width_p];

  logic                      resp_v_r;
  mc_op_e                    resp_op_r;
  logic [reg_id_width_c-1:0] resp_reg_id_r;
  logic [data_width_c-1:0]   rd_word_r;
  logic                      is_byte_r;
  logic [1:0]                byte_sel_r;
  logic                      pkt_fire;

  // take a packet when the response slot is free or leaving
  assign pkt_ready_o = ~resp_v_r | resp_ready_i;
  assign pkt_fire    = pkt_v_i & pkt_ready_o;

  always_ff @(posedge clk) begin
    if (!reset) begin
      resp_v_r <= 1'b0;
    end else if (pkt_fire) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  // byte-masked write, registered read
  always_ff @(posedge clk) begin
    if (pkt_fire) begin
      if (pkt_op_i == mc_op_store_e) begin
        for (int i = 0; i < mask_width_c; i++) begin
          if (pkt_mask_i[i]) begin
            mem[pkt_addr_i][8*i +: 8] <= pkt_payload_i.store_data[8*i +: 8];
          end
        end
      end
      rd_word_r <= mem[pkt_addr_i];
    end
  end

  // response fields
  always_ff @(posedge clk) begin
    if (pkt_fire) begin
      resp_op_r <= pkt_op_i;
      if (pkt_op_i == mc_op_load_e) begin
        resp_reg_id_r <= pkt_payload_i.load_info.reg_id;
        is_byte_r     <= pkt_payload_i.load_info.is_byte;
        byte_sel_r    <= pkt_payload_i.load_info.byte_sel;
      end else begin
        resp_reg_id_r <= '0;
        is_byte_r     <= 1'b0;
        byte_sel_r    <= 2'b00;
      end
    end
  end

  // load width decode on the read word
  always_comb begin
    if (resp_op_r == mc_op_store_e) begin
      resp_data_o = '0;
    end else if (is_byte_r) begin
      resp_data_o = {{(data_width_c-8){1'b0}}, rd_word_r[8*byte_sel_r +: 8]};
    end else begin
      resp_data_o = rd_word_r;
    end
  end

  assign resp_v_o      = resp_v_r;
  assign resp_op_o     = resp_op_r;
  assign resp_reg_id_o = resp_reg_id_r;

endmodule

//--- hdl/mc_traffic_profiler.sv
// mc_traffic_profiler: load, store and stall counters with print-stat snapshot

`timescale 1ns/1ps

module mc_traffic_profiler #(
  parameter int ctr_width_p = 32
) (
  input  logic                              clk,
  input  logic                              reset,

  input  logic                              cmd_fire_i,
  input  mc_pkg::mc_op_e                    cmd_op_i,
  input  logic                              stall_i,

  input  logic                              print_stat_v_i,
  input  logic [mc_pkg::data_width_c-1:0]   print_stat_tag_i,

  output logic                              stat_v_o,
  output logic [mc_pkg::data_width_c-1:0]   stat_tag_o,
  output logic [ctr_width_p-1:0]            load_count_o,
  output logic [ctr_width_p-1:0]            store_count_o,
  output logic [ctr_width_p-1:0]            stall_count_o
);

  import mc_pkg::*;

  logic [ctr_width_p-1:0] load_ctr_r, store_ctr_r, stall_ctr_r;
  logic [ctr_width_p-1:0] load_ctr_n, store_ctr_n, stall_ctr_n;
  logic                   stat_v_r;

  // counts including this cycle, so the strobe edge is reported too
  assign load_ctr_n  = load_ctr_r + ctr_width_p'(cmd_fire_i && (cmd_op_i == mc_op_load_e));
  assign store_ctr_n = store_ctr_r + ctr_width_p'(cmd_fire_i && (cmd_op_i == mc_op_store_e));
  assign stall_ctr_n = stall_ctr_r + ctr_width_p'(stall_i);

  always_ff @(posedge clk) begin
    if (!reset) begin
      load_ctr_r  <= '0;
      store_ctr_r <= '0;
      stall_ctr_r <= '0;
      stat_v_r    <= 1'b0;
    end else begin
      load_ctr_r  <= load_ctr_n;
      store_ctr_r <= store_ctr_n;
      stall_ctr_r <= stall_ctr_n;
      stat_v_r    <= print_stat_v_i;
    end
  end

  // snapshot holds until the next strobe
  always_ff @(posedge clk) begin
    if (print_stat_v_i) begin
      stat_tag_o    <= print_stat_tag_i;
      load_count_o  <= load_ctr_n;
      store_count_o <= store_ctr_n;
      stall_count_o <= stall_ctr_n;
    end
  end

  assign stat_v_o = stat_v_r;

endmodule

//--- hdl/mc_vcache_sys.sv
// mc_vcache_sys: top level joining issuer, packet FIFO, memory endpoint and profiler

`timescale 1ns/1ps

module mc_vcache_sys #(
  parameter int addr_width_p = 10,
  parameter int fifo_els_p   = 4,
  parameter int ctr_width_p  = 32
) (
  input  logic                                clk,
  input  logic                                reset,

  input  logic                                cmd_v_i,
  input  mc_pkg::mc_op_e                      cmd_op_i,
  input  logic [addr_width_p-1:0]             cmd_addr_i,
  input  logic [mc_pkg::mask_width_c-1:0]     cmd_mask_i,
  input  mc_pkg::mc_payload_u                 cmd_payload_i,
  output logic                                cmd_ready_o,

  output logic                                resp_v_o,
  output mc_pkg::mc_op_e                      resp_op_o,
  output logic [mc_pkg::reg_id_width_c-1:0]   resp_reg_id_o,
  output logic [mc_pkg::data_width_c-1:0]     resp_data_o,
  input  logic                                resp_ready_i,

  input  logic                                print_stat_v_i,
  input  logic [mc_pkg::data_width_c-1:0]     print_stat_tag_i,
  output logic                                stat_v_o,
  output logic [mc_pkg::data_width_c-1:0]     stat_tag_o,
  output logic [ctr_width_p-1:0]              load_count_o,
  output logic [ctr_width_p-1:0]              store_count_o,
  output logic [ctr_width_p-1:0]              stall_count_o
);

  import mc_pkg::*;

  // issuer to fifo
  logic                    pkt_v, pkt_ready;
  mc_op_e                  pkt_op;
  logic [addr_width_p-1:0] pkt_addr;
  logic [mask_width_c-1:0] pkt_mask;
  mc_payload_u             pkt_payload;

  // fifo to endpoint
  logic                    fifo_v, fifo_ready;
  mc_op_e                  fifo_op;
  logic [addr_width_p-1:0] fifo_addr;
  logic [mask_width_c-1:0] fifo_mask;
  mc_payload_u             fifo_payload;

  // profiler taps
  logic cmd_fire, stall;

  mc_req_issuer #(
    .addr_width_p(addr_width_p)
  ) u_issuer (
    .clk(clk)
    ,.reset(reset)
    ,.cmd_v_i(cmd_v_i)
    ,.cmd_op_i(cmd_op_i)
    ,.cmd_addr_i(cmd_addr_i)
    ,.cmd_mask_i(cmd_mask_i)
    ,.cmd_payload_i(cmd_payload_i)
    ,.cmd_ready_o(cmd_ready_o)
    ,.pkt_v_o(pkt_v)
    ,.pkt_op_o(pkt_op)
    ,.pkt_addr_o(pkt_addr)
    ,.pkt_mask_o(pkt_mask)
    ,.pkt_payload_o(pkt_payload)
    ,.pkt_ready_i(pkt_ready)
    ,.cmd_fire_o(cmd_fire)
    ,.stall_o(stall)
  );

  mc_pkt_fifo #(
    .addr_width_p(addr_width_p)
    ,.fifo_els_p(fifo_els_p)
  ) u_fifo (
    .clk(clk)
    ,.reset(reset)
    ,.v_i(pkt_v)
    ,.op_i(pkt_op)
    ,.addr_i(pkt_addr)
    ,.mask_i(pkt_mask)
    ,.payload_i(pkt_payload)
    ,.ready_o(pkt_ready)
    ,.v_o(fifo_v)
    ,.op_o(fifo_op)
    ,.addr_o(fifo_addr)
    ,.mask_o(fifo_mask)
    ,.payload_o(fifo_payload)
    ,.ready_i(fifo_ready)
  );

  mc_mem_endpoint #(
    .addr_width_p(addr_width_p)
  ) u_endpoint (
    .clk(clk)
    ,.reset(reset)
    ,.pkt_v_i(fifo_v)
    ,.pkt_op_i(fifo_op)
    ,.pkt_addr_i(fifo_addr)
    ,.pkt_mask_i(fifo_mask)
    ,.pkt_payload_i(fifo_payload)
    ,.pkt_ready_o(fifo_ready)
    ,.resp_v_o(resp_v_o)
    ,.resp_op_o(resp_op_o)
    ,.resp_reg_id_o(resp_reg_id_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_ready_i(resp_ready_i)
  );

  mc_traffic_profiler #(
    .ctr_width_p(ctr_width_p)
  ) u_profiler (
    .clk(clk)
    ,.reset(reset)
    ,.cmd_fire_i(cmd_fire)
    ,.cmd_op_i(cmd_op_i)
    ,.stall_i(stall)
    ,.print_stat_v_i(print_stat_v_i)
    ,.print_stat_tag_i(print_stat_tag_i)
    ,.stat_v_o(stat_v_o)
    ,.stat_tag_o(stat_tag_o)
    ,.load_count_o(load_count_o)
    ,.store_count_o(store_count_o)
    ,.stall_count_o(stall_count_o)
  );

endmodule

//--- tb/mc_vcache_sys_tb.sv
// mc_vcache_sys testbench with clock, reset, LCG stimulus, reference memory model and assertions

`timescale 1ns/1ps

module mc_vcache_sys_tb;

  import mc_pkg::*;

  localparam int addr_width_lp = 10;
  localparam int fifo_els_lp   = 4;
  localparam int ctr_width_lp  = 32;
  localparam int wait_limit_lp = 2000;

  typedef struct packed {
    mc_op_e                    op;
    logic [reg_id_width_c-1:0] reg_id;
    logic [data_width_c-1:0]   data;
  } exp_resp_s;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      cmd_v_i;
  mc_op_e                    cmd_op_i;
  logic [addr_width_lp-1:0]  cmd_addr_i;
  logic [mask_width_c-1:0]   cmd_mask_i;
  mc_payload_u               cmd_payload_i;
  logic                      cmd_ready_o;
  logic                      resp_v_o;
  mc_op_e                    resp_op_o;
  logic [reg_id_width_c-1:0] resp_reg_id_o;
  logic [data_width_c-1:0]   resp_data_o;
  logic                      resp_ready_i = 1'b1;
  logic                      print_stat_v_i;
  logic [data_width_c-1:0]   print_stat_tag_i;
  logic                      stat_v_o;
  logic [data_width_c-1:0]   stat_tag_o;
  logic [ctr_width_lp-1:0]   load_count_o;
  logic [ctr_width_lp-1:0]   store_count_o;
  logic [ctr_width_lp-1:0]   stall_count_o;

  logic [31:0]             lcg_state = 32'hc66bc09e;
  logic [31:0]             ready_rnd;
  logic                    rand_ready_en = 1'b0;
  logic [data_width_c-1:0] ref_mem [2**addr_width_lp];
  exp_resp_s               exp_q [$];
  exp_resp_s               exp_head = '0;
  logic                    exp_valid = 1'b0;
  exp_resp_s               fired;
  logic [data_width_c-1:0] rd_word;
  mc_load_info_s           li;

  int load_seen    = 0;
  int store_seen   = 0;
  int stall_seen   = 0;
  int resp_seen    = 0;
  int err_count    = 0;
  int err_mark     = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  always #10 clk = ~clk;

  mc_vcache_sys #(
    .addr_width_p(addr_width_lp)
    ,.fifo_els_p(fifo_els_lp)
    ,.ctr_width_p(ctr_width_lp)
  ) u_dut (
    .clk(clk)
    ,.reset(reset)
    ,.cmd_v_i(cmd_v_i)
    ,.cmd_op_i(cmd_op_i)
    ,.cmd_addr_i(cmd_addr_i)
    ,.cmd_mask_i(cmd_mask_i)
    ,.cmd_payload_i(cmd_payload_i)
    ,.cmd_ready_o(cmd_ready_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_op_o(resp_op_o)
    ,.resp_reg_id_o(resp_reg_id_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_ready_i(resp_ready_i)
    ,.print_stat_v_i(print_stat_v_i)
    ,.print_stat_tag_i(print_stat_tag_i)
    ,.stat_v_o(stat_v_o)
    ,.stat_tag_o(stat_tag_o)
    ,.load_count_o(load_count_o)
    ,.store_count_o(store_count_o)
    ,.stall_count_o(stall_count_o)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mc_payload_u store_payload(input logic [data_width_c-1:0] data);
    mc_payload_u p;
    p.store_data = data;
    return p;
  endfunction

  function automatic mc_payload_u load_payload(input logic is_byte, input logic [1:0] sel,
                                               input logic [reg_id_width_c-1:0] reg_id);
    mc_payload_u p;
    p.load_info.pad      = '0;
    p.load_info.is_byte  = is_byte;
    p.load_info.byte_sel = sel;
    p.load_info.reg_id   = reg_id;
    return p;
  endfunction

  // random host back-pressure when enabled
  always @(negedge clk) begin
    if (rand_ready_en) begin
      ready_rnd    = lcg_next();
      resp_ready_i = ready_rnd[17];
    end else begin
      resp_ready_i = 1'b1;
    end
  end

  // reference memory and expected responses in command order
  always @(posedge clk) begin
    if (reset) begin
      if (resp_v_o && resp_ready_i) begin
        resp_seen++;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (cmd_v_i && !cmd_ready_o) begin
        stall_seen++;
      end
      if (cmd_v_i && cmd_ready_o) begin
        if (cmd_op_i == mc_op_store_e) begin
          for (int b = 0; b < mask_width_c; b++) begin
            if (cmd_mask_i[b]) begin
              ref_mem[cmd_addr_i][8*b +: 8] = cmd_payload_i.store_data[8*b +: 8];
            end
          end
          fired = '{op: mc_op_store_e, reg_id: '0, data: '0};
          store_seen++;
        end else begin
          rd_word = ref_mem[cmd_addr_i];
          li      = cmd_payload_i.load_info;
          fired.op     = mc_op_load_e;
          fired.reg_id = li.reg_id;
          if (li.is_byte) begin
            fired.data = {24'h0, rd_word[8*li.byte_sel +: 8]};
          end else begin
            fired.data = rd_word;
          end
          load_seen++;
        end
        exp_q.push_back(fired);
      end
    end
  end

  // expected head settles on the falling edge
  always @(negedge clk) begin
    exp_valid = (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_head = exp_q[0];
    end else begin
      exp_head = '0;
    end
  end

  resp_expected_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && resp_ready_i) |-> exp_valid)
    else begin
      $display("response transferred with no command outstanding");
      err_count++;
    end

  resp_op_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && resp_ready_i && exp_valid) |-> (resp_op_o == exp_head.op))
    else begin
      $display("[FAIL] resp_op_o got %h expected %h", $sampled(resp_op_o), exp_head.op);
      err_count++;
    end

  resp_reg_id_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && resp_ready_i && exp_valid) |-> (resp_reg_id_o == exp_head.reg_id))
    else begin
      $display("[FAIL] resp_reg_id_o got %h expected %h", $sampled(resp_reg_id_o),
               exp_head.reg_id);
      err_count++;
    end

  resp_data_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && resp_ready_i && exp_valid) |-> (resp_data_o == exp_head.data))
    else begin
      $display("[FAIL] resp_data_o got %h expected %h", $sampled(resp_data_o), exp_head.data);
      err_count++;
    end

  // a stalled response must hold
  resp_hold_v_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && !resp_ready_i) |=> resp_v_o)
    else begin
      $display("resp_v_o dropped while resp_ready_i was low");
      err_count++;
    end

  resp_hold_fields_a: assert property (@(posedge clk) disable iff (!reset)
    (resp_v_o && !resp_ready_i) |=> ($stable(resp_data_o) && $stable(resp_reg_id_o)
                                     && $stable(resp_op_o)))
    else begin
      $display("[FAIL] resp_data_o %h resp_reg_id_o %h changed while resp_ready_i was low",
               $sampled(resp_data_o), $sampled(resp_reg_id_o));
      err_count++;
    end

  task automatic give_up(input string what);
    $display("timeout while %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("[FAIL] %s got %h expected %h", name, got, want);
      err_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_count == err_mark) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  // starts and ends on a falling edge
  task automatic send_cmd(input mc_op_e op, input logic [addr_width_lp-1:0] addr,
                          input logic [mask_width_c-1:0] mask, input mc_payload_u payload);
    int   waited;
    logic ready_now;
    waited        = 0;
    cmd_v_i       = 1'b1;
    cmd_op_i      = op;
    cmd_addr_i    = addr;
    cmd_mask_i    = mask;
    cmd_payload_i = payload;
    do begin
      ready_now = cmd_ready_o;
      @(posedge clk);
      @(negedge clk);
      waited++;
      if (waited > wait_limit_lp) begin
        give_up("waiting for cmd_ready_o");
      end
    end while (!ready_now);
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit_lp) begin
        give_up("waiting for outstanding responses");
      end
    end
    check_value("response count", 32'(resp_seen), 32'(load_seen + store_seen));
  endtask

  task automatic wait_cmd_ready();
    int waited;
    waited = 0;
    while (!cmd_ready_o) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit_lp) begin
        give_up("waiting for cmd_ready_o after reset");
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] tag;
    int          edges;
    reset            = 1'b0;
    cmd_v_i          = 1'b0;
    cmd_op_i         = mc_op_load_e;
    cmd_addr_i       = '0;
    cmd_mask_i       = '0;
    cmd_payload_i    = '0;
    print_stat_v_i   = 1'b0;
    print_stat_tag_i = '0;

    repeat (10) begin
      @(negedge clk);
      check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd0);
      check_value("resp_v_o", 32'(resp_v_o), 32'd0);
      check_value("stat_v_o", 32'(stat_v_o), 32'd0);
    end
    reset = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_value("resp_v_o", 32'(resp_v_o), 32'd0);
      check_value("stat_v_o", 32'(stat_v_o), 32'd0);
    end
    wait_cmd_ready();
    end_test("reset");

    send_cmd(mc_op_store_e, 10'h005, 4'hf, store_payload(32'ha5c3_1e77));
    send_cmd(mc_op_load_e, 10'h005, 4'h0, load_payload(1'b0, 2'd0, 5'd7));
    wait_drain();
    end_test("store_load");

    // bytes 11, 22, 33, 44 arrive through three partial stores
    send_cmd(mc_op_store_e, 10'h02a, 4'hf, store_payload(32'h0));
    send_cmd(mc_op_store_e, 10'h02a, 4'b0001, store_payload(32'hdead_be11));
    send_cmd(mc_op_store_e, 10'h02a, 4'b0100, store_payload(32'hff33_eeee));
    send_cmd(mc_op_store_e, 10'h02a, 4'b1010, store_payload(32'h44cc_22dd));
    send_cmd(mc_op_load_e, 10'h02a, 4'h0, load_payload(1'b0, 2'd0, 5'd1));
    for (int s = 0; s < 4; s++) begin
      send_cmd(mc_op_load_e, 10'h02a, 4'h0, load_payload(1'b1, 2'(s), 5'(s + 2)));
    end
    wait_drain();
    end_test("byte_merge");

    // window at 0x100 is written first so every load hits known data
    rand_ready_en = 1'b1;
    for (int i = 0; i < 16; i++) begin
      send_cmd(mc_op_store_e, {6'h10, 4'(i)}, 4'hf, store_payload(lcg_next()));
    end
    for (int i = 0; i < 200; i++) begin
      r = lcg_next();
      if (r[31]) begin
        send_cmd(mc_op_store_e, {6'h10, r[27:24]}, r[23:20], store_payload(lcg_next()));
      end else begin
        send_cmd(mc_op_load_e, {6'h10, r[27:24]}, 4'h0, load_payload(r[19], r[18:17], r[16:12]));
      end
    end
    wait_drain();
    rand_ready_en = 1'b0;
    end_test("random_traffic");

    @(negedge clk);
    send_cmd(mc_op_load_e, 10'h100, 4'h0, load_payload(1'b0, 2'd0, 5'd9));
    edges = 0;
    while (!resp_v_o) begin
      @(posedge clk);
      @(negedge clk);
      edges++;
      if (edges > 20) begin
        give_up("waiting for resp_v_o");
      end
    end
    check_value("response latency", 32'(edges), 32'd3);
    wait_drain();
    end_test("latency");

    tag              = lcg_next();
    print_stat_v_i   = 1'b1;
    print_stat_tag_i = tag;
    // this store lands on the strobe edge and belongs in the snapshot
    send_cmd(mc_op_store_e, 10'h3ff, 4'hf, store_payload(tag));
    print_stat_v_i = 1'b0;
    check_value("stat_v_o", 32'(stat_v_o), 32'd1);
    check_value("stat_tag_o", stat_tag_o, tag);
    check_value("load_count_o", load_count_o, 32'(load_seen));
    check_value("store_count_o", store_count_o, 32'(store_seen));
    check_value("stall_count_o", stall_count_o, 32'(stall_seen));
    @(negedge clk);
    check_value("stat_v_o", 32'(stat_v_o), 32'd0);
    wait_drain();
    end_test("print_stat");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- mc_vcache_sys.f
hdl/mc_pkg.sv
hdl/mc_req_issuer.sv
hdl/mc_pkt_fifo.sv
hdl/mc_mem_endpoint.sv
hdl/mc_traffic_profiler.sv
hdl/mc_vcache_sys.sv
tb/mc_vcache_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mc_vcache_sys testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mc_vcache_sys_tb \
  -f mc_vcache_sys.f \
  -Mdir obj_dir -o mc_vcache_sys_sim

./obj_dir/mc_vcache_sys_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
